// File: design/tcdm_pkg.sv
/*
 * shared localparams of the tcdm request funnel
 * channel counts, group sizing, address, data and byte-enable widths
 */
`default_nettype none

package tcdm_pkg;

  // channel counts
  // input channel j is served by port (j mod NB_OUT_CHAN)
  localparam int unsigned NB_IN_CHAN  = 4;
  localparam int unsigned NB_OUT_CHAN = 2;

  // channels that share one port
  localparam int unsigned NB_GRP = NB_IN_CHAN / NB_OUT_CHAN;

  // group index and rotation counter width
  // kept at least one bit wide so a single-channel group still has a slot index
  localparam int unsigned GRP_W = (NB_GRP > 1) ? $clog2(NB_GRP) : 1;

  // bank-local word address
  localparam int unsigned AW = 6;

  // data path
  localparam int unsigned DW  = 32;
  localparam int unsigned BW  = 8;
  localparam int unsigned BEW = DW / BW;

  // depth of every bank in words
  localparam int unsigned BANK_WORDS = 2 ** AW;

endpackage

`default_nettype wire

// File: design/rr_counter.sv
/*
 * round-robin rotation offset shared by all port arbiters
 * advances on granted traffic, wraps at the group size, clears on command
 */
`timescale 1ns/1ns
`default_nettype none

module rr_counter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear,
  input  logic                       adv,
  output logic [tcdm_pkg::GRP_W-1:0] rr_count
);

  import tcdm_pkg::*;

  // last legal offset before wrapping back to slot 0
  localparam logic [GRP_W-1:0] LAST = GRP_W'(NB_GRP - 1);

  logic [GRP_W-1:0] count_d;

  // next offset, modulo the group size
  // group size need not be a power of two, so wrap explicitly
  always_comb begin
    if (rr_count == LAST) begin
      count_d = '0;
    end else begin
      count_d = rr_count + GRP_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_count <= '0;
    end else if (clear) begin
      // clear wins over a grant in the same cycle
      rr_count <= '0;
    end else if (adv) begin
      // any port granted this cycle
      rr_count <= count_d;
    end
  end

endmodule

`default_nettype wire

// File: design/chan_arbiter.sv
/*
 * per-port arbiter for one group of input channels
 * rotating priority winner search, request mux to the bank,
 * grant return and one-cycle read response routing
 */
`timescale 1ns/1ns
`default_nettype none

module chan_arbiter (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear,
  input  logic                                           req_en,
  input  logic [tcdm_pkg::GRP_W-1:0]                     rr_count,
  input  logic [tcdm_pkg::GRP_W-1:0]                     port_idx,
  // group side
  input  logic [tcdm_pkg::NB_GRP-1:0]                    grp_req,
  input  logic [tcdm_pkg::NB_GRP-1:0][tcdm_pkg::AW-1:0]  grp_add,
  input  logic [tcdm_pkg::NB_GRP-1:0]                    grp_wen,
  input  logic [tcdm_pkg::NB_GRP-1:0][tcdm_pkg::BEW-1:0] grp_be,
  input  logic [tcdm_pkg::NB_GRP-1:0][tcdm_pkg::DW-1:0]  grp_data,
  output logic [tcdm_pkg::NB_GRP-1:0]                    grp_gnt,
  output logic [tcdm_pkg::NB_GRP-1:0][tcdm_pkg::DW-1:0]  grp_r_data,
  output logic [tcdm_pkg::NB_GRP-1:0]                    grp_r_valid,
  // bank side
  output logic                                           out_req,
  output logic [tcdm_pkg::AW-1:0]                        out_add,
  output logic                                           out_wen,
  output logic [tcdm_pkg::BEW-1:0]                       out_be,
  output logic [tcdm_pkg::DW-1:0]                        out_data,
  input  logic                                           out_gnt,
  input  logic [tcdm_pkg::DW-1:0]                        out_r_data,
  input  logic                                           out_r_valid,
  // status towards the counter and the clear FSM
  output logic                                           granted,
  output logic                                           pending
);

  import tcdm_pkg::*;

  logic [GRP_W-1:0] winner_d;
  logic [GRP_W-1:0] winner_q;
  logic             any_req;
  logic             read_q;

  // winner search
  // priority order is slot (rr_count + port_idx), then the next one, modulo NB_GRP
  always_comb begin
    int unsigned base;
    int unsigned slot;
    logic        found;
    base  = int'(rr_count) + int'(port_idx);
    found = 1'b0;
    // with no request the top-priority slot is picked, nothing is forwarded anyway
    winner_d = GRP_W'(base % NB_GRP);
    for (int k = 0; k < NB_GRP; k++) begin
      slot = (base + k) % NB_GRP;
      if (!found && grp_req[slot]) begin
        winner_d = GRP_W'(slot);
        found    = 1'b1;
      end
    end
  end

  // request towards the bank, held off while the clear FSM is not in RUN
  assign any_req = |grp_req;
  assign out_req = req_en & any_req;

  // payload of the winner
  assign out_add  = grp_add[winner_d];
  assign out_wen  = grp_wen[winner_d];
  assign out_be   = grp_be[winner_d];
  assign out_data = grp_data[winner_d];

  assign granted = out_req & out_gnt;

  // grant goes back to the winner only
  always_comb begin
    grp_gnt           = '0;
    grp_gnt[winner_d] = granted;
  end

  // remember who owns the response of this cycle's read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      winner_q <= '0;
      read_q   <= 1'b0;
    end else if (clear) begin
      winner_q <= '0;
      read_q   <= 1'b0;
    end else begin
      // writes return nothing, so only reads arm the response path
      read_q <= granted & out_wen;
      if (granted) begin
        winner_q <= winner_d;
      end
    end
  end

  // response routing, the other slots see zero
  always_comb begin
    grp_r_valid           = '0;
    grp_r_data            = '0;
    grp_r_valid[winner_q] = out_r_valid & read_q;
    grp_r_data[winner_q]  = out_r_data;
  end

  // a read was issued and its data has not come back yet
  // one-cycle banks answer in the cycle after the grant, so this only
  // rises for a slower bank
  assign pending = read_q & ~out_r_valid;

endmodule

`default_nettype wire

// File: design/tcdm_bank.sv
/*
 * single-port word-addressed memory bank
 * byte-enable writes, registered read data one cycle after the grant
 */
`timescale 1ns/1ns
`default_nettype none

module tcdm_bank (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req,
  input  logic [tcdm_pkg::AW-1:0]    add,
  input  logic                       wen,
  input  logic [tcdm_pkg::BEW-1:0]   be,
  input  logic [tcdm_pkg::DW-1:0]    data,
  output logic                       gnt,
  output logic [tcdm_pkg::DW-1:0]    r_data,
  output logic                       r_valid
);

  import tcdm_pkg::*;

  logic [DW-1:0] mem [BANK_WORDS];

  logic wr_en;
  logic rd_en;

  // never stalls
  assign gnt = req;

  // wen high is a read
  assign wr_en = req & ~wen;
  assign rd_en = req & wen;

  // storage, only the enabled bytes change
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < BEW; b++) begin
      if (wr_en && be[b]) begin
        mem[add][b*BW +: BW] <= data[b*BW +: BW];
      end
    end
  end

  // read data register, holds its value between reads
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data <= mem[add];
    end
  end

  // response strobe for the cycle after a read grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= rd_en;
    end
  end

endmodule

`default_nettype wire

// File: design/clear_fsm.sv
/*
 * control FSM for an external clear request
 * gates new requests, drains the read in flight, then pulses clear
 */
`timescale 1ns/1ns
`default_nettype none

module clear_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_req,
  input  logic resp_pending,
  output logic req_en,
  output logic clear,
  output logic busy
);

  // RUN passes traffic, DRAIN and CLEAR hold it off
  typedef enum logic [1:0] {
    RUN   = 2'd0,
    DRAIN = 2'd1,
    CLEAR = 2'd2
  } state_t;

  state_t state_q;
  state_t state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RUN: begin
        // grants of this cycle still go through
        if (clear_req) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // a read granted in the last RUN cycle returns here
        if (!resp_pending) begin
          state_d = CLEAR;
        end
      end
      CLEAR: begin
        // one-cycle clear pulse, then traffic resumes
        state_d = RUN;
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // outputs decoded from the state alone
  assign req_en = (state_q == RUN);
  assign busy   = (state_q != RUN);
  assign clear  = (state_q == CLEAR);

endmodule

`default_nettype wire

// File: design/tcdm_mux_top.sv
/*
 * top level of the tcdm request funnel
 * clear FSM, round-robin counter, one arbiter and one bank per port
 */
`timescale 1ns/1ns
`default_nettype none

module tcdm_mux_top (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               clear_req,
  input  logic [tcdm_pkg::NB_IN_CHAN-1:0]                    in_req,
  input  logic [tcdm_pkg::NB_IN_CHAN-1:0][tcdm_pkg::AW-1:0]  in_add,
  input  logic [tcdm_pkg::NB_IN_CHAN-1:0]                    in_wen,
  input  logic [tcdm_pkg::NB_IN_CHAN-1:0][tcdm_pkg::BEW-1:0] in_be,
  input  logic [tcdm_pkg::NB_IN_CHAN-1:0][tcdm_pkg::DW-1:0]  in_data,
  output logic [tcdm_pkg::NB_IN_CHAN-1:0]                    in_gnt,
  output logic [tcdm_pkg::NB_IN_CHAN-1:0][tcdm_pkg::DW-1:0]  in_r_data,
  output logic [tcdm_pkg::NB_IN_CHAN-1:0]                    in_r_valid,
  output logic                                               busy
);

  import tcdm_pkg::*;

  // control
  logic             req_en;
  logic             clear;
  logic             adv;
  logic             resp_pending;
  logic [GRP_W-1:0] rr_count;

  // per-port status
  logic [NB_OUT_CHAN-1:0] granted;
  logic [NB_OUT_CHAN-1:0] pending;

  // bank side, one entry per port
  logic [NB_OUT_CHAN-1:0]          out_req;
  logic [NB_OUT_CHAN-1:0][AW-1:0]  out_add;
  logic [NB_OUT_CHAN-1:0]          out_wen;
  logic [NB_OUT_CHAN-1:0][BEW-1:0] out_be;
  logic [NB_OUT_CHAN-1:0][DW-1:0]  out_data;
  logic [NB_OUT_CHAN-1:0]          out_gnt;
  logic [NB_OUT_CHAN-1:0][DW-1:0]  out_r_data;
  logic [NB_OUT_CHAN-1:0]          out_r_valid;

  // input channels regrouped per port, [port][slot]
  logic [NB_OUT_CHAN-1:0][NB_GRP-1:0]          grp_req;
  logic [NB_OUT_CHAN-1:0][NB_GRP-1:0][AW-1:0]  grp_add;
  logic [NB_OUT_CHAN-1:0][NB_GRP-1:0]          grp_wen;
  logic [NB_OUT_CHAN-1:0][NB_GRP-1:0][BEW-1:0] grp_be;
  logic [NB_OUT_CHAN-1:0][NB_GRP-1:0][DW-1:0]  grp_data;
  logic [NB_OUT_CHAN-1:0][NB_GRP-1:0]          grp_gnt;
  logic [NB_OUT_CHAN-1:0][NB_GRP-1:0][DW-1:0]  grp_r_data;
  logic [NB_OUT_CHAN-1:0][NB_GRP-1:0]          grp_r_valid;

  // counter steps when any port moved a request
  assign adv          = |granted;
  assign resp_pending = |pending;

  clear_fsm u_clear_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_req    (clear_req),
    .resp_pending (resp_pending),
    .req_en       (req_en),
    .clear        (clear),
    .busy         (busy)
  );

  rr_counter u_rr_counter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear    (clear),
    .adv      (adv),
    .rr_count (rr_count)
  );

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : g_port

    // slot k of port i is input channel k*NB_OUT_CHAN + i
    for (genvar k = 0; k < NB_GRP; k++) begin : g_slot
      assign grp_req[i][k]  = in_req[k*NB_OUT_CHAN+i];
      assign grp_add[i][k]  = in_add[k*NB_OUT_CHAN+i];
      assign grp_wen[i][k]  = in_wen[k*NB_OUT_CHAN+i];
      assign grp_be[i][k]   = in_be[k*NB_OUT_CHAN+i];
      assign grp_data[i][k] = in_data[k*NB_OUT_CHAN+i];

      assign in_gnt[k*NB_OUT_CHAN+i]     = grp_gnt[i][k];
      assign in_r_data[k*NB_OUT_CHAN+i]  = grp_r_data[i][k];
      assign in_r_valid[k*NB_OUT_CHAN+i] = grp_r_valid[i][k];
    end

    chan_arbiter u_arb (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .clear       (clear),
      .req_en      (req_en),
      .rr_count    (rr_count),
      // port offset into the shared rotation
      .port_idx    (GRP_W'(i % NB_GRP)),
      .grp_req     (grp_req[i]),
      .grp_add     (grp_add[i]),
      .grp_wen     (grp_wen[i]),
      .grp_be      (grp_be[i]),
      .grp_data    (grp_data[i]),
      .grp_gnt     (grp_gnt[i]),
      .grp_r_data  (grp_r_data[i]),
      .grp_r_valid (grp_r_valid[i]),
      .out_req     (out_req[i]),
      .out_add     (out_add[i]),
      .out_wen     (out_wen[i]),
      .out_be      (out_be[i]),
      .out_data    (out_data[i]),
      .out_gnt     (out_gnt[i]),
      .out_r_data  (out_r_data[i]),
      .out_r_valid (out_r_valid[i]),
      .granted     (granted[i]),
      .pending     (pending[i])
    );

    tcdm_bank u_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req     (out_req[i]),
      .add     (out_add[i]),
      .wen     (out_wen[i]),
      .be      (out_be[i]),
      .data    (out_data[i]),
      .gnt     (out_gnt[i]),
      .r_data  (out_r_data[i]),
      .r_valid (out_r_valid[i])
    );

  end

endmodule

`default_nettype wire

// File: dv/tb_tcdm_mux.sv
/*
 * testbench for the tcdm request funnel
 * replays per-cycle stimulus and expected values from a data file,
 * checks grants, read responses, read data and busy
 */
`timescale 1ns/1ns
`default_nettype none

module tb_tcdm_mux;

  import tcdm_pkg::*;

  localparam int    HALF_PERIOD   = 50;
  localparam int    CLK_PERIOD    = 2 * HALF_PERIOD;
  localparam int    RESET_CYCLES  = 10;
  localparam int    DRIVE_DELAY   = 1;
  localparam int    MARGIN_CYCLES = 20;
  localparam string INPUT_FILE    = "dv/tcdm_input.txt";

  // DUT ports
  logic                                clk_i = 1'b0;
  logic                                rst_ni;
  logic                                clear_req;
  logic [NB_IN_CHAN-1:0]               in_req;
  logic [NB_IN_CHAN-1:0][AW-1:0]       in_add;
  logic [NB_IN_CHAN-1:0]               in_wen;
  logic [NB_IN_CHAN-1:0][BEW-1:0]      in_be;
  logic [NB_IN_CHAN-1:0][DW-1:0]       in_data;
  logic [NB_IN_CHAN-1:0]               in_gnt;
  logic [NB_IN_CHAN-1:0][DW-1:0]       in_r_data;
  logic [NB_IN_CHAN-1:0]               in_r_valid;
  logic                                busy;

  // one entry per stimulus line
  string                               tag_q[$];
  logic                                clr_q[$];
  logic [NB_IN_CHAN-1:0]               req_q[$];
  logic [NB_IN_CHAN-1:0][AW-1:0]       add_q[$];
  logic [NB_IN_CHAN-1:0]               wen_q[$];
  logic [NB_IN_CHAN-1:0][BEW-1:0]      be_q[$];
  logic [NB_IN_CHAN-1:0][DW-1:0]       data_q[$];
  logic [NB_IN_CHAN-1:0]               exp_gnt_q[$];
  logic [NB_IN_CHAN-1:0]               exp_valid_q[$];
  // expected read data per port for the channel that is valid
  logic [NB_OUT_CHAN-1:0][DW-1:0]      exp_rdata_q[$];
  logic                                exp_busy_q[$];

  logic load_ok      = 1'b1;
  int   cycle_count  = 0;
  int   cycle_limit  = 0;
  int   test_errors  = 0;
  int   test_steps   = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;

  tcdm_mux_top dut_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_req  (clear_req),
    .in_req     (in_req),
    .in_add     (in_add),
    .in_wen     (in_wen),
    .in_be      (in_be),
    .in_data    (in_data),
    .in_gnt     (in_gnt),
    .in_r_data  (in_r_data),
    .in_r_valid (in_r_valid),
    .busy       (busy)
  );

  // 100 ns clock
  always #HALF_PERIOD clk_i = ~clk_i;

  // watchdog with a limit set once the file length is known
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic drive_idle();
    clear_req = 1'b0;
    in_req    = '0;
    in_add    = '0;
    in_wen    = '0;
    in_be     = '0;
    in_data   = '0;
  endtask

  // lines whose first token starts with # are skipped
  task automatic load_stimulus();
    int                             fd;
    int                             cnt;
    string                          tok;
    string                          rest;
    logic [31:0]                    f_clr;
    logic [31:0]                    f_req;
    logic [31:0]                    f_add;
    logic [31:0]                    f_wen;
    logic [31:0]                    f_be;
    logic [31:0]                    f_data;
    logic [31:0]                    f_gnt;
    logic [31:0]                    f_val;
    logic [31:0]                    f_rd0;
    logic [31:0]                    f_rd1;
    logic [31:0]                    f_busy;
    logic [NB_IN_CHAN-1:0]          req_v;
    logic [NB_IN_CHAN-1:0][AW-1:0]  add_v;
    logic [NB_IN_CHAN-1:0]          wen_v;
    logic [NB_IN_CHAN-1:0][BEW-1:0] be_v;
    logic [NB_IN_CHAN-1:0][DW-1:0]  data_v;
    logic [NB_OUT_CHAN-1:0][DW-1:0] rd_v;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", INPUT_FILE);
      load_ok = 1'b0;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        cnt = $fgets(rest, fd);
        continue;
      end
      cnt = $fscanf(fd, "%h", f_clr);
      // per channel the fields are req add wen be data
      for (int j = 0; j < NB_IN_CHAN; j++) begin
        cnt += $fscanf(fd, "%h %h %h %h %h", f_req, f_add, f_wen, f_be, f_data);
        req_v[j]  = f_req[0];
        add_v[j]  = f_add[AW-1:0];
        wen_v[j]  = f_wen[0];
        be_v[j]   = f_be[BEW-1:0];
        data_v[j] = f_data[DW-1:0];
      end
      cnt += $fscanf(fd, "%h %h %h %h %h", f_gnt, f_val, f_rd0, f_rd1, f_busy);
      if (cnt != 6 + 5 * NB_IN_CHAN) begin
        $display("malformed stimulus line in test %s", tok);
        load_ok = 1'b0;
      end
      rd_v[0] = f_rd0[DW-1:0];
      rd_v[1] = f_rd1[DW-1:0];
      tag_q.push_back(tok);
      clr_q.push_back(f_clr[0]);
      req_q.push_back(req_v);
      add_q.push_back(add_v);
      wen_q.push_back(wen_v);
      be_q.push_back(be_v);
      data_q.push_back(data_v);
      exp_gnt_q.push_back(f_gnt[NB_IN_CHAN-1:0]);
      exp_valid_q.push_back(f_val[NB_IN_CHAN-1:0]);
      exp_rdata_q.push_back(rd_v);
      exp_busy_q.push_back(f_busy[0]);
    end
    $fclose(fd);
    if (tag_q.size() == 0) begin
      $display("the stimulus file holds no stimulus lines");
      load_ok = 1'b0;
    end
  endtask

  task automatic apply_line(int n);
    clear_req = clr_q[n];
    in_req    = req_q[n];
    in_add    = add_q[n];
    in_wen    = wen_q[n];
    in_be     = be_q[n];
    in_data   = data_q[n];
  endtask

  // true when some channel served by port p expects a response
  function automatic logic port_responds(logic [NB_IN_CHAN-1:0] valid, int p);
    logic hit;
    hit = 1'b0;
    for (int c = 0; c < NB_IN_CHAN; c++) begin
      if (c % NB_OUT_CHAN == p && valid[c]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic check_line(int n);
    string name;
    name = tag_q[n];
    if (in_gnt !== exp_gnt_q[n]) begin
      $display("Fail %s step %0d: in_gnt expected %h actual %h",
               name, n, exp_gnt_q[n], in_gnt);
      test_errors++;
    end
    if (in_r_valid !== exp_valid_q[n]) begin
      $display("Fail %s step %0d: in_r_valid expected %h actual %h",
               name, n, exp_valid_q[n], in_r_valid);
      test_errors++;
    end
    if (busy !== exp_busy_q[n]) begin
      $display("Fail %s step %0d: busy expected %b actual %b",
               name, n, exp_busy_q[n], busy);
      test_errors++;
    end
    // data only counts on a channel that should see a response
    for (int j = 0; j < NB_IN_CHAN; j++) begin
      if (exp_valid_q[n][j] && in_r_data[j] !== exp_rdata_q[n][j % NB_OUT_CHAN]) begin
        $display("Fail %s step %0d: in_r_data[%0d] expected %h actual %h",
                 name, n, j, exp_rdata_q[n][j % NB_OUT_CHAN], in_r_data[j]);
        test_errors++;
      end
    end
    // the neighbours of a responding channel on the same port see zero data
    for (int j = 0; j < NB_IN_CHAN; j++) begin
      if (!exp_valid_q[n][j] && port_responds(exp_valid_q[n], j % NB_OUT_CHAN)
          && in_r_data[j] !== '0) begin
        $display("Fail %s step %0d: in_r_data[%0d] expected %h actual %h",
                 name, n, j, {DW{1'b0}}, in_r_data[j]);
        test_errors++;
      end
    end
  endtask

  task automatic close_test(string name);
    if (test_errors == 0) begin
      $display("test %s passed, %0d cycles", name, test_steps);
      tests_passed++;
    end else begin
      $display("test %s failed, %0d mismatches", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
    test_steps  = 0;
  endtask

  initial begin
    rst_ni = 1'b0;
    drive_idle();
    load_stimulus();
    cycle_limit = tag_q.size() + MARGIN_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;
    if (load_ok) begin
      for (int n = 0; n < tag_q.size(); n++) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
        apply_line(n);
        // sample 1 ns ahead of the next rising edge
        #(CLK_PERIOD - DRIVE_DELAY - 1);
        check_line(n);
        test_steps++;
        // a test ends where the tag changes
        if (n + 1 == tag_q.size()) begin
          close_test(tag_q[n]);
        end else if (tag_q[n + 1] != tag_q[n]) begin
          close_test(tag_q[n]);
        end
      end
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    drive_idle();
    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (load_ok && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tcdm_input.txt
# tag clear_req | ch0 ch1 ch2 ch3 as: req add wen be data (wen 1 = read) | all values hex
# expected: gnt_vec valid_vec rdata_port0 rdata_port1 busy (rdata checked on valid channels)
rst 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
rst 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
rst 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
wr 0  1 01 0 f 11110000  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 0 0 0 0
wr 0  0 0 0 0 0  1 02 0 f 22221111  0 0 0 0 0  0 0 0 0 0  2 0 0 0 0
wr 0  0 0 0 0 0  0 0 0 0 0  1 03 0 f 33332222  0 0 0 0 0  4 0 0 0 0
wr 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 04 0 f 44443333  8 0 0 0 0
rd 0  1 01 1 f 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 0 0 0 0
rd 0  0 0 0 0 0  1 02 1 f 0  0 0 0 0 0  0 0 0 0 0  2 1 11110000 0 0
rd 0  0 0 0 0 0  0 0 0 0 0  1 03 1 f 0  0 0 0 0 0  4 2 0 22221111 0
rd 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 04 1 f 0  8 4 33332222 0 0
rd 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 8 0 44443333 0
be 0  1 01 0 3 0000abcd  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 0 0 0 0
be 0  0 0 0 0 0  1 02 0 c 5a5a0000  0 0 0 0 0  0 0 0 0 0  2 0 0 0 0
be 0  0 0 0 0 0  0 0 0 0 0  1 01 0 4 00ee0000  0 0 0 0 0  4 0 0 0 0
be 0  1 01 1 f 0  0 0 0 0 0  0 0 0 0 0  1 02 1 f 0  9 0 0 0 0
be 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 9 11eeabcd 5a5a1111 0
cont 0  1 10 0 f a0a0a0a0  1 12 0 f b1b1b1b1  1 11 0 f c2c2c2c2  1 13 0 f d3d3d3d3  9 0 0 0 0
cont 0  0 0 0 0 0  1 12 0 f b1b1b1b1  1 11 0 f c2c2c2c2  0 0 0 0 0  6 0 0 0 0
cont 0  1 11 1 f 0  1 13 1 f 0  1 10 1 f 0  1 12 1 f 0  9 0 0 0 0
cont 0  1 10 1 f 0  1 13 1 f 0  1 10 1 f 0  1 13 1 f 0  6 9 c2c2c2c2 b1b1b1b1 0
cont 0  1 10 1 f 0  0 0 0 0 0  0 0 0 0 0  1 13 1 f 0  9 6 a0a0a0a0 d3d3d3d3 0
cont 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 9 a0a0a0a0 d3d3d3d3 0
rout 0  0 0 0 0 0  0 0 0 0 0  1 03 1 f 0  0 0 0 0 0  4 0 0 0 0
rout 0  1 05 0 f 5555aaaa  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 4 33332222 0 0
rout 0  0 0 0 0 0  1 04 1 f 0  0 0 0 0 0  0 0 0 0 0  2 0 0 0 0
rout 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 02 1 f 0  8 2 0 44443333 0
rout 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 8 0 5a5a1111 0
clr 0  0 0 0 0 0  1 06 0 f 66661111  0 0 0 0 0  0 0 0 0 0  2 0 0 0 0
clr 1  1 05 1 f 0  0 0 0 0 0  1 01 1 f 0  0 0 0 0 0  1 0 0 0 0
clr 0  0 0 0 0 0  1 02 1 f 0  1 01 1 f 0  1 04 1 f 0  0 1 5555aaaa 0 1
clr 0  0 0 0 0 0  1 02 1 f 0  1 01 1 f 0  1 04 1 f 0  0 0 0 0 1
clr 0  1 03 1 f 0  1 02 1 f 0  1 01 1 f 0  1 04 1 f 0  9 0 0 0 0
clr 0  0 0 0 0 0  1 02 1 f 0  1 01 1 f 0  0 0 0 0 0  6 9 33332222 44443333 0
clr 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 6 11eeabcd 5a5a1111 0

// File: list.f
design/tcdm_pkg.sv
design/rr_counter.sv
design/chan_arbiter.sv
design/tcdm_bank.sv
design/clear_fsm.sv
design/tcdm_mux_top.sv
dv/tb_tcdm_mux.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_tcdm_mux \
  -Mdir obj_dir -o vsim \
  && ./obj_dir/vsim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "^Verification passed$" sim.log \
  && { echo "simulation result: pass"; exit 0; } \
  || { echo "simulation result: fail"; exit 1; }
